/* mips_core.f */
hw/isa_pkg.sv
hw/core_pkg.sv
hw/word_memory.sv
hw/imem_loader.sv
hw/fetch_unit.sv
hw/register_file.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/writeback_unit.sv
hw/mips_core.sv
verification/mips_core_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mips_core_tb -f mips_core.f -o mips_core_sim
./obj_dir/mips_core_sim | tee sim.log

if grep -F -x -q '** PASS **' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* verification/mips_core_tb.sv */
`timescale 1ns/1ps

module mips_core_tb import core_pkg::*, isa_pkg::*; ();

	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;
	localparam int PROG_LEN = 60;
	localparam int TIMEOUT_CYCLES = 4 * PROG_LEN + 200;

	logic clock;
	logic reset;
	logic run;
	logic load_req;
	instr_t load_word;
	logic load_ack;
	logic wb_valid;
	logic [REG_ADDR_W-1:0] wb_reg;
	word_t wb_data;

	instr_t prog [PROG_LEN];
	logic [REG_ADDR_W-1:0] exp_reg [PROG_LEN];
	word_t exp_data [PROG_LEN];
	int last_write [8];
	int exp_count = 0;
	int commit_idx = 0;
	int errors = 0;
	int cycles = 0;
	int unsigned rng_state = 98539;
	string stage_name = "reset";

	mips_core #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) mips_core_i (
		.clock(clock),
		.reset(reset),
		.run(run),
		.load_req(load_req),
		.load_word(load_word),
		.load_ack(load_ack),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic int unsigned rand_below(int unsigned range);
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return (rng_state >> 16) % range;
	endfunction

	function automatic instr_t r_type(int rs, int rt, int rd, int shamt, logic [5:0] funct);
		return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
	endfunction

	function automatic instr_t i_type(logic [5:0] opcode, int rs, int rt, logic [15:0] imm);
		return {opcode, 5'(rs), 5'(rt), imm};
	endfunction

	// Ready means never written or written three or more slots back
	function automatic int pick_source(int pos);
		int start;
		int r;
		start = int'(rand_below(8));
		for (int k = 0; k < 8; k++) begin
			r = (start + k) % 8;
			if (r == 0 || last_write[r] <= pos - 3)
				return r;
		end
		return -1;
	endfunction

	task automatic build_program();
		logic [5:0] functs [9];
		int kind;
		int src_a;
		int src_b;
		int dest;
		int shamt;
		functs = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLL, FN_SRL};
		prog[0] = i_type(OP_ADDIU, 0, 0, 16'h7fff); // Dropped write to r0
		prog[1] = i_type(OP_LW, 0, 1, 16'h0100); // Stores never reach 0x100
		prog[2] = i_type(OP_LUI, 0, 3, 16'habcd);
		prog[3] = i_type(OP_ORI, 0, 2, 16'h1234); // r0 must read zero here
		prog[4] = '0;
		prog[5] = i_type(OP_SW, 0, 3, 16'h0020);
		prog[6] = i_type(OP_LW, 0, 4, 16'h0020);
		for (int r = 0; r < 8; r++)
			last_write[r] = -100;
		last_write[1] = 1;
		last_write[2] = 3;
		last_write[3] = 2;
		last_write[4] = 6;
		for (int i = 7; i < PROG_LEN; i++) begin
			kind = int'(rand_below(14));
			dest = int'(rand_below(8)); // r0 included on purpose
			shamt = int'(rand_below(32));
			src_a = pick_source(i);
			src_b = pick_source(i);
			if (src_a < 0 || src_b < 0) begin
				prog[i] = '0;
				continue;
			end
			case (kind)
				9: prog[i] = i_type(OP_ADDIU, src_a, dest, 16'(rand_below(65536)));
				10: prog[i] = i_type(OP_ORI, src_a, dest, 16'(rand_below(65536)));
				11: prog[i] = i_type(OP_LUI, 0, dest, 16'(rand_below(65536)));
				12: prog[i] = i_type(OP_LW, 0, dest, 16'(rand_below(16) * 4));
				13: prog[i] = i_type(OP_SW, 0, src_b, 16'(rand_below(16) * 4));
				default: begin
					if (kind >= 7)
						prog[i] = r_type(0, src_b, dest, shamt, functs[kind]);
					else
						prog[i] = r_type(src_a, src_b, dest, 0, functs[kind]);
				end
			endcase
			if (kind != 13)
				last_write[dest] = i;
		end
	endtask

	// Sequential ISA model, one instruction at a time
	task automatic run_model();
		word_t regs [NUM_REGS];
		word_t dmem [DMEM_DEPTH];
		instr_t w;
		word_t sext;
		word_t a;
		word_t b;
		word_t value;
		int dest;
		int idx;
		logic writes;
		for (int r = 0; r < NUM_REGS; r++)
			regs[r] = '0;
		for (int m = 0; m < DMEM_DEPTH; m++)
			dmem[m] = '0;
		for (int i = 0; i < PROG_LEN; i++) begin
			w = prog[i];
			sext = {{16{w[15]}}, w[15:0]};
			a = regs[w.rs];
			b = regs[w.rt];
			idx = int'(((a + sext) >> 2) & word_t'(DMEM_DEPTH - 1));
			dest = int'(w.rt);
			writes = 1'b1;
			value = '0;
			case (w.opcode)
				OP_RTYPE: begin
					dest = int'(w.rd);
					case (w.funct)
						FN_ADDU: value = a + b;
						FN_SUBU: value = a - b;
						FN_AND: value = a & b;
						FN_OR: value = a | b;
						FN_XOR: value = a ^ b;
						FN_NOR: value = ~(a | b);
						FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						FN_SLL: value = b << w.shamt;
						FN_SRL: value = b >> w.shamt;
						default: writes = 1'b0;
					endcase
				end
				OP_ADDIU: value = a + sext;
				OP_ORI: value = a | {16'h0000, w[15:0]};
				OP_LUI: value = {w[15:0], 16'h0000};
				OP_LW: value = dmem[idx];
				OP_SW: begin
					dmem[idx] = b;
					writes = 1'b0;
				end
				default: writes = 1'b0;
			endcase
			if (writes && dest != 0) begin
				regs[dest] = value;
				exp_reg[exp_count] = 5'(dest);
				exp_data[exp_count] = value;
				exp_count++;
			end
		end
	endtask

	always @(posedge clock) begin
		if (reset)
			commit_idx <= 0;
		else if (wb_valid)
			commit_idx <= commit_idx + 1;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles while %s", cycles, stage_name);
			$display("** FAIL **");
			$finish;
		end
	end

	a_ack_timing: assert property (@(posedge clock) disable iff (reset)
		$rose(load_ack) |-> $past(load_req, 1) && $past(load_req, 2) && !$past(load_req, 3))
	else begin
		errors++;
		$display("load_ack rose at %0t but not two edges after load_req rose", $time);
	end

	a_ack_release: assert property (@(posedge clock) disable iff (reset)
		$fell(load_ack) |-> !load_req)
	else begin
		errors++;
		$display("load_ack fell at %0t while load_req was still high", $time);
	end

	a_idle_quiet: assert property (@(negedge clock) disable iff (reset) !run |-> !wb_valid)
	else begin
		errors++;
		$display("commit seen at %0t while run was low", $time);
	end

	a_no_extra: assert property (@(negedge clock) disable iff (reset)
		wb_valid |-> commit_idx < exp_count)
	else begin
		errors++;
		$display("extra commit to r%0d at %0t beyond the %0d expected", wb_reg, $time, exp_count);
	end

	a_commit_reg: assert property (@(negedge clock) disable iff (reset)
		wb_valid && commit_idx < exp_count |-> wb_reg == exp_reg[commit_idx])
	else begin
		errors++;
		$display("mismatch at %0t: wb_reg got %0d expected %0d",
			$time, wb_reg, exp_reg[commit_idx]);
	end

	a_commit_data: assert property (@(negedge clock) disable iff (reset)
		wb_valid && commit_idx < exp_count |-> wb_data == exp_data[commit_idx])
	else begin
		errors++;
		$display("mismatch at %0t: wb_data got %h expected %h",
			$time, wb_data, exp_data[commit_idx]);
	end

	initial begin : main
		int err_start;
		reset = 1'b1;
		run = 1'b0;
		load_req = 1'b0;
		load_word = '0;
		build_program();
		run_model();
		repeat (3) @(posedge clock);
		#2;
		reset = 1'b0;

		stage_name = "loading the program";
		err_start = errors;
		for (int i = 0; i < PROG_LEN; i++) begin
			load_word = prog[i];
			load_req = 1'b1;
			do
				@(negedge clock);
			while (!load_ack);
			@(posedge clock);
			#2;
			load_req = 1'b0;
			do
				@(negedge clock);
			while (load_ack);
			@(posedge clock);
			#2;
		end
		$display("test load_handshake: %0d words, %0d errors", PROG_LEN, errors - err_start);

		stage_name = "idling before run";
		err_start = errors;
		repeat (8) @(posedge clock);
		#2;
		$display("test idle_quiet: %0d errors", errors - err_start);

		stage_name = "waiting for commits";
		err_start = errors;
		run = 1'b1;
		while (commit_idx < exp_count)
			@(posedge clock);
		$display("test commit_stream: %0d commits, %0d errors", commit_idx, errors - err_start);

		stage_name = "draining the pipeline";
		err_start = errors;
		repeat (8) @(posedge clock); // Trailing zero words are NOPs
		a_all_commits: assert (commit_idx == exp_count)
		else begin
			errors++;
			$display("saw %0d commits where %0d were expected", commit_idx, exp_count);
		end
		$display("test drain_check: %0d errors", errors - err_start);

		$display("tests: 4, commits: %0d of %0d, errors: %0d", commit_idx, exp_count, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* hw/mips_core.sv */
`timescale 1ns/1ps

module mips_core import core_pkg::*, isa_pkg::*; #(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input logic clock,
	input logic reset,
	input logic run,
	input logic load_req,
	input instr_t load_word,
	output logic load_ack,
	output logic wb_valid,
	output logic [REG_ADDR_W-1:0] wb_reg,
	output word_t wb_data
);

	localparam int IMEM_W = $clog2(IMEM_DEPTH);
	localparam int DMEM_W = $clog2(DMEM_DEPTH);

	logic imem_write_en;
	logic [IMEM_W-1:0] imem_write_index;
	word_t imem_write_data;
	logic [IMEM_W-1:0] imem_read_index;
	instr_t imem_read_data;
	logic fetch_valid;

	logic [REG_ADDR_W-1:0] rs_index;
	logic [REG_ADDR_W-1:0] rt_index;
	word_t rs_data;
	word_t rt_data;
	logic rf_write_en;
	logic [REG_ADDR_W-1:0] rf_write_index;
	word_t rf_write_data;

	logic x_valid;
	alu_op_t x_op;
	word_t x_a;
	word_t x_b;
	word_t x_store_data;
	logic [REG_ADDR_W-1:0] x_dest;
	logic x_is_load;
	logic x_is_store;
	logic x_writes;

	logic m_valid;
	word_t m_result;
	logic [REG_ADDR_W-1:0] m_dest;
	logic m_is_load;
	logic m_writes;

	logic dmem_write_en;
	logic [DMEM_W-1:0] dmem_index;
	word_t dmem_write_data;
	word_t dmem_read_data;

	imem_loader #(.IMEM_DEPTH(IMEM_DEPTH)) imem_loader_i (
		.clock(clock),
		.reset(reset),
		.load_req(load_req),
		.load_word(load_word),
		.load_ack(load_ack),
		.mem_write_en(imem_write_en),
		.mem_write_index(imem_write_index),
		.mem_write_data(imem_write_data)
	);

	fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_unit_i (
		.clock(clock),
		.reset(reset),
		.run(run),
		.mem_read_index(imem_read_index),
		.fetch_valid(fetch_valid)
	);

	word_memory #(.DEPTH(IMEM_DEPTH), .payload_t(instr_t)) imem_i (
		.clock(clock),
		.write_en(imem_write_en),
		.write_index(imem_write_index),
		.write_data(imem_write_data),
		.read_index(imem_read_index),
		.read_data(imem_read_data)
	);

	register_file register_file_i (
		.clock(clock),
		.reset(reset),
		.rs_index(rs_index),
		.rt_index(rt_index),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.write_en(rf_write_en),
		.write_index(rf_write_index),
		.write_data(rf_write_data)
	);

	decode_unit decode_unit_i (
		.clock(clock),
		.reset(reset),
		.in_valid(fetch_valid),
		.instr(imem_read_data),
		.rs_index(rs_index),
		.rt_index(rt_index),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.x_valid(x_valid),
		.x_op(x_op),
		.x_a(x_a),
		.x_b(x_b),
		.x_store_data(x_store_data),
		.x_dest(x_dest),
		.x_is_load(x_is_load),
		.x_is_store(x_is_store),
		.x_writes(x_writes)
	);

	execute_unit #(.DMEM_DEPTH(DMEM_DEPTH)) execute_unit_i (
		.clock(clock),
		.reset(reset),
		.x_valid(x_valid),
		.x_op(x_op),
		.x_a(x_a),
		.x_b(x_b),
		.x_store_data(x_store_data),
		.x_dest(x_dest),
		.x_is_load(x_is_load),
		.x_is_store(x_is_store),
		.x_writes(x_writes),
		.m_valid(m_valid),
		.m_result(m_result),
		.m_dest(m_dest),
		.m_is_load(m_is_load),
		.m_writes(m_writes),
		.dmem_write_en(dmem_write_en),
		.dmem_index(dmem_index),
		.dmem_write_data(dmem_write_data)
	);

	// Single port, read and write share the index
	word_memory #(.DEPTH(DMEM_DEPTH), .payload_t(word_t)) dmem_i (
		.clock(clock),
		.write_en(dmem_write_en),
		.write_index(dmem_index),
		.write_data(dmem_write_data),
		.read_index(dmem_index),
		.read_data(dmem_read_data)
	);

	writeback_unit writeback_unit_i (
		.clock(clock),
		.reset(reset),
		.m_valid(m_valid),
		.m_result(m_result),
		.m_dest(m_dest),
		.m_is_load(m_is_load),
		.m_writes(m_writes),
		.dmem_read_data(dmem_read_data),
		.rf_write_en(rf_write_en),
		.rf_write_index(rf_write_index),
		.rf_write_data(rf_write_data),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

endmodule

/* hw/writeback_unit.sv */
`timescale 1ns/1ps

module writeback_unit import core_pkg::*, isa_pkg::*; (
	input logic clock,
	input logic reset,
	input logic m_valid,
	input word_t m_result,
	input logic [REG_ADDR_W-1:0] m_dest,
	input logic m_is_load,
	input logic m_writes,
	input word_t dmem_read_data,
	output logic rf_write_en,
	output logic [REG_ADDR_W-1:0] rf_write_index,
	output word_t rf_write_data,
	output logic wb_valid,
	output logic [REG_ADDR_W-1:0] wb_reg,
	output word_t wb_data
);

	word_t result;

	// Load data arrives from memory during this stage
	assign result = m_is_load ? dmem_read_data : m_result;

	always_ff @(posedge clock) begin
		if (reset)
			wb_valid <= 1'b0;
		else
			wb_valid <= m_valid && m_writes;
		wb_reg <= m_dest;
		wb_data <= result;
	end

	// Commit port and register write see one value
	assign rf_write_en = wb_valid;
	assign rf_write_index = wb_reg;
	assign rf_write_data = wb_data;

endmodule

/* hw/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit import core_pkg::*, isa_pkg::*; #(
	parameter int DMEM_DEPTH = 256
) (
	input logic clock,
	input logic reset,
	input logic x_valid,
	input alu_op_t x_op,
	input word_t x_a,
	input word_t x_b,
	input word_t x_store_data,
	input logic [REG_ADDR_W-1:0] x_dest,
	input logic x_is_load,
	input logic x_is_store,
	input logic x_writes,
	output logic m_valid,
	output word_t m_result,
	output logic [REG_ADDR_W-1:0] m_dest,
	output logic m_is_load,
	output logic m_writes,
	output logic dmem_write_en,
	output logic [$clog2(DMEM_DEPTH)-1:0] dmem_index,
	output word_t dmem_write_data
);

	localparam int INDEX_W = $clog2(DMEM_DEPTH);

	word_t result;

	always_comb begin
		case (x_op)
			ALU_ADD: result = x_a + x_b;
			ALU_SUB: result = x_a - x_b;
			ALU_AND: result = x_a & x_b;
			ALU_OR: result = x_a | x_b;
			ALU_XOR: result = x_a ^ x_b;
			ALU_NOR: result = ~(x_a | x_b);
			ALU_SLT: result = ($signed(x_a) < $signed(x_b)) ? 32'd1 : 32'd0;
			ALU_SLL: result = x_a << x_b[4:0];
			ALU_SRL: result = x_a >> x_b[4:0];
			ALU_LUI: result = {x_b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

	// Byte address to word index, wrapping at DMEM_DEPTH
	assign dmem_index = result[INDEX_W+1:2];
	assign dmem_write_en = x_valid && x_is_store;
	assign dmem_write_data = x_store_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			m_valid <= 1'b0;
			m_is_load <= 1'b0;
			m_writes <= 1'b0;
		end else begin
			m_valid <= x_valid;
			m_is_load <= x_is_load;
			m_writes <= x_writes;
		end
		m_result <= result;
		m_dest <= x_dest;
	end

endmodule

/* hw/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit import core_pkg::*, isa_pkg::*; (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input instr_t instr,
	output logic [REG_ADDR_W-1:0] rs_index,
	output logic [REG_ADDR_W-1:0] rt_index,
	input word_t rs_data,
	input word_t rt_data,
	output logic x_valid,
	output alu_op_t x_op,
	output word_t x_a,
	output word_t x_b,
	output word_t x_store_data,
	output logic [REG_ADDR_W-1:0] x_dest,
	output logic x_is_load,
	output logic x_is_store,
	output logic x_writes
);

	logic [15:0] imm;
	word_t imm_sext;
	word_t imm_zext;
	alu_op_t op;
	word_t a;
	word_t b;
	logic [REG_ADDR_W-1:0] dest;
	logic writes;
	logic is_load;
	logic is_store;

	assign rs_index = instr.rs;
	assign rt_index = instr.rt;
	assign imm = instr[15:0];
	assign imm_sext = {{(DATA_W-16){imm[15]}}, imm};
	assign imm_zext = {{(DATA_W-16){1'b0}}, imm};

	always_comb begin
		op = ALU_ADD;
		a = rs_data;
		b = rt_data;
		dest = instr.rd;
		writes = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		case (instr.opcode)
			OP_RTYPE: begin
				writes = 1'b1;
				case (instr.funct)
					FN_ADDU: op = ALU_ADD;
					FN_SUBU: op = ALU_SUB;
					FN_AND: op = ALU_AND;
					FN_OR: op = ALU_OR;
					FN_XOR: op = ALU_XOR;
					FN_NOR: op = ALU_NOR;
					FN_SLT: op = ALU_SLT;
					FN_SLL, FN_SRL: begin
						op = (instr.funct == FN_SLL) ? ALU_SLL : ALU_SRL;
						a = rt_data; // Shifts work on rt
						b = {{(DATA_W-5){1'b0}}, instr.shamt};
					end
					default: writes = 1'b0; // Unknown funct acts as NOP
				endcase
			end
			OP_ADDIU: begin
				b = imm_sext;
				dest = instr.rt;
				writes = 1'b1;
			end
			OP_ORI: begin
				op = ALU_OR;
				b = imm_zext;
				dest = instr.rt;
				writes = 1'b1;
			end
			OP_LUI: begin
				op = ALU_LUI;
				b = imm_zext;
				dest = instr.rt;
				writes = 1'b1;
			end
			OP_LW: begin
				b = imm_sext;
				dest = instr.rt;
				writes = 1'b1;
				is_load = 1'b1;
			end
			OP_SW: begin
				b = imm_sext;
				is_store = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			x_valid <= 1'b0;
			x_is_load <= 1'b0;
			x_is_store <= 1'b0;
			x_writes <= 1'b0;
		end else begin
			x_valid <= in_valid;
			x_is_load <= is_load;
			x_is_store <= is_store;
			x_writes <= writes && (dest != '0); // r0 targets never commit
		end
		x_op <= op;
		x_a <= a;
		x_b <= b;
		x_store_data <= rt_data;
		x_dest <= dest;
	end

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps

module register_file import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic [$clog2(NUM_REGS)-1:0] rs_index,
	input logic [$clog2(NUM_REGS)-1:0] rt_index,
	output word_t rs_data,
	output word_t rt_data,
	input logic write_en,
	input logic [$clog2(NUM_REGS)-1:0] write_index,
	input word_t write_data
);

	word_t regs [NUM_REGS];
	logic write_live;

	assign write_live = write_en && (write_index != '0);

	// Same-cycle write bypasses straight to decode
	assign rs_data = (write_live && write_index == rs_index) ? write_data : regs[rs_index];
	assign rt_data = (write_live && write_index == rt_index) ? write_data : regs[rt_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (write_live) begin
			regs[write_index] <= write_data; // r0 never written
		end
	end

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; #(
	parameter int IMEM_DEPTH = 256
) (
	input logic clock,
	input logic reset,
	input logic run,
	output logic [$clog2(IMEM_DEPTH)-1:0] mem_read_index,
	output logic fetch_valid
);

	localparam int INDEX_W = $clog2(IMEM_DEPTH);

	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] offset;

	assign offset = pc - START_ADDR;
	assign mem_read_index = offset[INDEX_W+1:2]; // Wraps past the end

	// fetch_valid qualifies the word coming out of memory next cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= START_ADDR;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= run;
			if (run)
				pc <= pc + 32'd4;
		end
	end

	a_pc_aligned: assert property (@(posedge clock) disable iff (reset) pc[1:0] == 2'b00);

endmodule

/* hw/imem_loader.sv */
`timescale 1ns/1ps

module imem_loader import core_pkg::*; #(
	parameter int IMEM_DEPTH = 256
) (
	input logic clock,
	input logic reset,
	input logic load_req,
	input word_t load_word,
	output logic load_ack,
	output logic mem_write_en,
	output logic [$clog2(IMEM_DEPTH)-1:0] mem_write_index,
	output word_t mem_write_data
);

	typedef enum logic {IDLE, ACKING} state_t;

	state_t state;
	logic [$clog2(IMEM_DEPTH)-1:0] index;

	// Word goes in on the edge that first sees the request
	assign mem_write_en = (state == IDLE) && load_req;
	assign mem_write_index = index;
	assign mem_write_data = load_word;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			index <= '0;
			load_ack <= 1'b0;
		end else begin
			case (state)
				IDLE: if (load_req) begin
					index <= index + 1'b1;
					state <= ACKING;
				end
				ACKING: if (!load_ack) begin
					load_ack <= 1'b1;
				end else if (!load_req) begin
					load_ack <= 1'b0; // Four-phase return to zero
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
		$rose(load_ack) |-> load_req);

endmodule

/* hw/word_memory.sv */
`timescale 1ns/1ps

module word_memory #(
	parameter int DEPTH = 256,
	parameter type payload_t = logic [31:0]
) (
	input logic clock,
	input logic write_en,
	input logic [$clog2(DEPTH)-1:0] write_index,
	input payload_t write_data,
	input logic [$clog2(DEPTH)-1:0] read_index,
	output payload_t read_data
);

	payload_t mem [DEPTH];

	// Unloaded words read back as zero
	initial begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clock) begin
		if (write_en)
			mem[write_index] <= write_data;
		read_data <= mem[read_index]; // Old data on a same-index write
	end

	a_index_range: assert property (@(posedge clock)
		(32'(read_index) < DEPTH) && (!write_en || 32'(write_index) < DEPTH));

endmodule

/* hw/core_pkg.sv */
package core_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 32; // Byte addresses

	typedef logic [DATA_W-1:0] word_t;

	// Instruction memory index 0 sits here
	localparam logic [ADDR_W-1:0] START_ADDR = 32'h80020000;

	localparam int NUM_REGS = 32;

endpackage

/* hw/isa_pkg.sv */
package isa_pkg;

	localparam int REG_ADDR_W = 5;

	typedef struct packed {
		logic [5:0] opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_t; // Immediate is the low 16 bits

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
	} alu_op_t;

	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_LUI   = 6'b001111;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SW    = 6'b101011;

	// R-type function codes
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;

endpackage
